// ==== source/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // one raw instruction word
    typedef logic [31:0] instr_t;

    // major opcode, bits 31 to 22
    typedef logic [9:0] opcode_t;

    // signed immediate, bits 21 to 10
    typedef logic [11:0] imm12_t;

    // register index, rj at bits 9 to 5, rd at bits 4 to 0
    typedef logic [4:0] reg_idx_t;

    // architectural register value
    typedef logic [31:0] word_t;

    // addi.w major opcode
    localparam opcode_t op_addi_w = 10'b0000001010;

    // general purpose registers, r0 hardwired to zero
    localparam int num_regs = 32;

endpackage

`default_nettype wire

// ==== source/frontend_pkg.sv ====
`default_nettype none

package frontend_pkg;

    // byte address of an instruction
    typedef logic [31:0] pc_t;

    // instruction pair, slot 0 in the upper half
    typedef logic [63:0] bundle_t;

    // event counters
    typedef logic [31:0] count_t;

    // two issue slots per bundle
    localparam int num_slots = 2;

    localparam pc_t reset_pc = 32'd0;

    // pc advance for one or two instructions
    localparam pc_t step_single = 32'd4;
    localparam pc_t step_pair = 32'd8;

endpackage

`default_nettype wire

// ==== source/fetch_pc.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_pc (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic              flush,
    input  wire logic              stall,
    input  wire frontend_pkg::pc_t redirect_pc,
    input  wire logic              fetch_pair,
    output frontend_pkg::pc_t      pc
);
    import frontend_pkg::*;

    pc_t pc_step;
    pc_t pc_next;

    // a pair moves two words ahead, a single slot only one
    assign pc_step = fetch_pair ? step_pair : step_single;

    always_comb begin
        // redirect wins over everything
        if (flush) begin
            pc_next = redirect_pc;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + pc_step;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/icache_stub.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_stub (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic              flush,
    input  wire logic              stall,
    input  wire frontend_pkg::pc_t pc,
    output logic                   fetch_pair,
    output frontend_pkg::bundle_t  bundle,
    output logic                   pair_flag,
    output logic                   bundle_valid
);
    import isa_pkg::*;
    import frontend_pkg::*;

    bundle_t rom_pair;
    logic    rom_flag;

    // builds addi.w rd, rj, 1
    function automatic instr_t addi_one(input reg_idx_t rd, input reg_idx_t rj);
        return {op_addi_w, imm12_t'(1), rj, rd};
    endfunction

    // program rom, lookup on the current pc
    always_comb begin
        case (pc)
            // r1++ r3++
            32'd0: begin
                rom_pair = {addi_one(5'd1, 5'd1), addi_one(5'd3, 5'd3)};
                rom_flag = 1'b1;
            end
            32'd8: begin
                rom_pair = {addi_one(5'd1, 5'd1), addi_one(5'd3, 5'd3)};
                rom_flag = 1'b1;
            end
            // r1++ then r5=r1+1, slot 1 needs the fresh r1
            32'd16: begin
                rom_pair = {addi_one(5'd1, 5'd1), addi_one(5'd5, 5'd1)};
                rom_flag = 1'b1;
            end
            // r5=r3+1 r4++
            32'd24: begin
                rom_pair = {addi_one(5'd5, 5'd3), addi_one(5'd4, 5'd4)};
                rom_flag = 1'b1;
            end
            // zero word, decodes as illegal
            32'd40: begin
                rom_pair = '0;
                rom_flag = 1'b0;
            end
            // everything else is a lone r4++
            default: begin
                rom_pair = {addi_one(5'd4, 5'd4), addi_one(5'd4, 5'd4)};
                rom_flag = 1'b0;
            end
        endcase
    end

    // unregistered flag, lets the pc choose its step this cycle
    assign fetch_pair = rom_flag;

    // registered bundle, flush clears, stall freezes
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bundle       <= '0;
            pair_flag    <= 1'b0;
            bundle_valid <= 1'b0;
        end else if (flush) begin
            bundle       <= '0;
            pair_flag    <= 1'b0;
            bundle_valid <= 1'b0;
        end else if (!stall) begin
            bundle       <= rom_pair;
            pair_flag    <= rom_flag;
            bundle_valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/slot_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module slot_decoder (
    input  wire logic             slot_valid,
    input  wire isa_pkg::instr_t  instr,
    output logic                  dec_valid,
    output logic                  illegal,
    output isa_pkg::reg_idx_t     rd,
    output isa_pkg::reg_idx_t     rj,
    output isa_pkg::word_t        imm
);
    import isa_pkg::*;

    opcode_t opcode;
    imm12_t  imm12;
    logic    is_addi_w;

    // field split
    assign opcode = instr[31:22];
    assign imm12  = instr[21:10];
    assign rj     = instr[9:5];
    assign rd     = instr[4:0];

    // sign extend the 12-bit immediate
    assign imm = {{20{imm12[11]}}, imm12};

    assign is_addi_w = (opcode == op_addi_w);

    // only addi.w is supported
    assign dec_valid = slot_valid & is_addi_w;

    // anything else in a live slot is counted as illegal
    assign illegal = slot_valid & ~is_addi_w;

endmodule

`default_nettype wire

// ==== source/issue_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_regfile (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic              stall,
    input  wire logic              dec_valid [frontend_pkg::num_slots],
    input  wire logic              illegal [frontend_pkg::num_slots],
    input  wire isa_pkg::reg_idx_t rd [frontend_pkg::num_slots],
    input  wire isa_pkg::reg_idx_t rj [frontend_pkg::num_slots],
    input  wire isa_pkg::word_t    imm [frontend_pkg::num_slots],
    input  wire isa_pkg::reg_idx_t dbg_addr,
    output isa_pkg::word_t         dbg_data,
    output frontend_pkg::count_t   commit_count,
    output frontend_pkg::count_t   illegal_count
);
    import isa_pkg::*;
    import frontend_pkg::*;

    word_t  regs [num_regs];
    word_t  src0;
    word_t  src1;
    word_t  res0;
    word_t  res1;
    logic   fwd_1;
    count_t commit_inc;
    count_t illegal_inc;

    // r0 is never written, so a plain read gives zero
    assign src0 = regs[rj[0]];
    assign res0 = src0 + imm[0];

    // slot 1 sees slot 0's result when it reads the same nonzero rd
    assign fwd_1 = dec_valid[0] & (rd[0] != 5'd0) & (rj[1] == rd[0]);
    assign src1  = fwd_1 ? res0 : regs[rj[1]];
    assign res1  = src1 + imm[1];

    assign dbg_data = regs[dbg_addr];

    // per bundle event totals
    always_comb begin
        commit_inc  = '0;
        illegal_inc = '0;
        for (int s = 0; s < num_slots; s++) begin
            commit_inc  = commit_inc + count_t'(dec_valid[s]);
            illegal_inc = illegal_inc + count_t'(illegal[s]);
        end
    end

    // commit in program order, slot 1 last so it wins on equal rd
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int r = 0; r < num_regs; r++) begin
                regs[r] <= '0;
            end
        end else if (!stall) begin
            if (dec_valid[0] && rd[0] != 5'd0) begin
                regs[rd[0]] <= res0;
            end
            if (dec_valid[1] && rd[1] != 5'd0) begin
                regs[rd[1]] <= res1;
            end
        end
    end

    // counters freeze with the pipe
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            commit_count  <= '0;
            illegal_count <= '0;
        end else if (!stall) begin
            commit_count  <= commit_count + commit_inc;
            illegal_count <= illegal_count + illegal_inc;
        end
    end

endmodule

`default_nettype wire

// ==== source/frontend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frontend_top (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic              flush,
    input  wire frontend_pkg::pc_t redirect_pc,
    input  wire logic              stall,
    output frontend_pkg::count_t   commit_count,
    output frontend_pkg::count_t   illegal_count,
    input  wire isa_pkg::reg_idx_t dbg_addr,
    output isa_pkg::word_t         dbg_data
);
    import isa_pkg::*;
    import frontend_pkg::*;

    pc_t      pc;
    logic     fetch_pair;
    bundle_t  bundle;
    logic     pair_flag;
    logic     bundle_valid;

    // per slot decode results
    logic     slot_valid [num_slots];
    logic     dec_valid [num_slots];
    logic     illegal [num_slots];
    reg_idx_t dec_rd [num_slots];
    reg_idx_t dec_rj [num_slots];
    word_t    dec_imm [num_slots];

    fetch_pc u_fetch_pc (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .stall       (stall),
        .redirect_pc (redirect_pc),
        .fetch_pair  (fetch_pair),
        .pc          (pc)
    );

    icache_stub u_icache_stub (
        .clk          (clk),
        .rstn         (rstn),
        .flush        (flush),
        .stall        (stall),
        .pc           (pc),
        .fetch_pair   (fetch_pair),
        .bundle       (bundle),
        .pair_flag    (pair_flag),
        .bundle_valid (bundle_valid)
    );

    // slot 0 takes the upper word, slot 1 only counts when paired
    for (genvar i = 0; i < num_slots; i++) begin : g_slot
        assign slot_valid[i] = bundle_valid & ((i == 0) | pair_flag);

        slot_decoder u_slot_decoder (
            .slot_valid (slot_valid[i]),
            .instr      (bundle[(num_slots - 1 - i) * 32 +: 32]),
            .dec_valid  (dec_valid[i]),
            .illegal    (illegal[i]),
            .rd         (dec_rd[i]),
            .rj         (dec_rj[i]),
            .imm        (dec_imm[i])
        );
    end

    issue_regfile u_issue_regfile (
        .clk           (clk),
        .rstn          (rstn),
        .stall         (stall),
        .dec_valid     (dec_valid),
        .illegal       (illegal),
        .rd            (dec_rd),
        .rj            (dec_rj),
        .imm           (dec_imm),
        .dbg_addr      (dbg_addr),
        .dbg_data      (dbg_data),
        .commit_count  (commit_count),
        .illegal_count (illegal_count)
    );

endmodule

`default_nettype wire

// ==== bench/frontend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module frontend_tb;
    import isa_pkg::*;
    import frontend_pkg::*;

    // about 70 cycles of tests plus margin
    localparam int max_cycles = 400;

    logic     clk;
    logic     rstn;
    logic     flush;
    logic     stall;
    pc_t      redirect_pc;
    reg_idx_t dbg_addr;
    word_t    dbg_data;
    count_t   commit_count;
    count_t   illegal_count;

    // reference model state with one bundle in flight
    word_t       m_regs [32];
    word_t       snap [32];
    pc_t         m_pc;
    logic        m_bv;
    logic [21:0] m_bundle;
    count_t      m_commits;
    count_t      m_illegal;
    count_t      base;
    int          n_checks;
    int          n_errors;
    int          cycles;

    frontend_top uut (
        .clk           (clk),
        .rstn          (rstn),
        .flush         (flush),
        .redirect_pc   (redirect_pc),
        .stall         (stall),
        .commit_count  (commit_count),
        .illegal_count (illegal_count),
        .dbg_addr      (dbg_addr),
        .dbg_data      (dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // program table as {pair, slot 0 legal, rd0, rj0, rd1, rj1}
    // every word adds 1
    function automatic logic [21:0] rom_rule(input pc_t pc);
        case (pc)
            32'd0, 32'd8: return {2'b11, 5'd1, 5'd1, 5'd3, 5'd3};
            32'd16:       return {2'b11, 5'd1, 5'd1, 5'd5, 5'd1};
            32'd24:       return {2'b11, 5'd5, 5'd3, 5'd4, 5'd4};
            32'd40:       return {2'b00, 20'd0};
            default:      return {2'b01, 5'd4, 5'd4, 5'd0, 5'd0};
        endcase
    endfunction

    // program order lets slot 1 see slot 0's write
    task automatic model_commit(input logic [21:0] b);
        if (b[20]) begin
            if (b[19:15] != 5'd0) begin
                m_regs[b[19:15]] = m_regs[b[14:10]] + 32'd1;
            end
            m_commits++;
        end else begin
            m_illegal++;
        end
        if (b[21]) begin
            if (b[9:5] != 5'd0) begin
                m_regs[b[9:5]] = m_regs[b[4:0]] + 32'd1;
            end
            m_commits++;
        end
    endtask

    // model steps on the dut clock edges and reads only driven inputs
    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            m_regs    = '{default: '0};
            m_pc      = 32'd0;
            m_bv      = 1'b0;
            m_commits = 32'd0;
            m_illegal = 32'd0;
        end else begin
            if (!stall && m_bv) begin
                model_commit(m_bundle);
            end
            // redirect beats stall and drops the in-flight bundle
            if (flush) begin
                m_bv = 1'b0;
                m_pc = redirect_pc;
            end else if (!stall) begin
                m_bundle = rom_rule(m_pc);
                m_bv     = 1'b1;
                m_pc     = m_pc + (m_bundle[21] ? 32'd8 : 32'd4);
            end
        end
    end

    task automatic check(input string name, input word_t exp, input word_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    // combinational debug read after a short settle
    task automatic read_reg(input int r, output word_t v);
        dbg_addr = 5'(r);
        #1;
        v = dbg_data;
    endtask

    task automatic check_reg(input string name, input int r, input word_t exp);
        word_t v;
        read_reg(r, v);
        check($sformatf("%s r%0d", name, r), exp, v);
    endtask

    // whole register file plus both counters against the model
    task automatic check_regs(input string name, input word_t exp_regs [32]);
        for (int r = 0; r < 32; r++) begin
            check_reg(name, r, exp_regs[r]);
        end
        check({name, " commit_count"}, m_commits, commit_count);
        check({name, " illegal_count"}, m_illegal, illegal_count);
    endtask

    task automatic wait_commits(input count_t target);
        while (commit_count < target) begin
            next_cycle();
        end
    endtask

    task automatic test_reset();
        next_cycle();
        rstn = 1'b0;
        flush = 1'b0;
        stall = 1'b0;
        repeat (8) next_cycle();
        rstn = 1'b1;
        // bundle_valid is still low so nothing has landed yet
        snap = '{default: '0};
        check_regs("test_reset", snap);
        check("test_reset commit_count", 32'd0, commit_count);
        check("test_reset illegal_count", 32'd0, illegal_count);
    endtask

    task automatic test_program();
        wait_commits(32'd12);
        check_reg("test_program", 1, 32'd3);
        check_reg("test_program", 3, 32'd2);
        // forwarded r5 of pc 16 was overwritten at pc 24
        check_reg("test_program", 5, 32'd3);
        check_reg("test_program", 4, m_commits - 32'd7);
        check("test_program illegal_count", 32'd1, illegal_count);
        check_regs("test_program", m_regs);
    endtask

    task automatic test_forwarding();
        next_cycle();
        flush = 1'b1;
        redirect_pc = 32'd16;
        next_cycle();
        flush = 1'b0;
        base = m_commits;
        wait_commits(base + 32'd2);
        check("test_forwarding commit_count", base + 32'd2, commit_count);
        // r5 must see the r1 written one slot earlier
        check_reg("test_forwarding", 5, m_regs[1] + 32'd1);
        check_regs("test_forwarding", m_regs);
    endtask

    task automatic test_stall();
        next_cycle();
        stall = 1'b1;
        snap = m_regs;
        base = m_commits;
        repeat (10) begin
            next_cycle();
            check("test_stall commit_count", base, commit_count);
        end
        stall = 1'b0;
        // state stays frozen until the next edge
        check_regs("test_stall", snap);
        wait_commits(base + 32'd1);
        check_regs("test_stall resume", m_regs);
    endtask

    task automatic test_flush_replay();
        next_cycle();
        flush = 1'b1;
        redirect_pc = 32'd0;
        next_cycle();
        flush = 1'b0;
        snap = m_regs;
        base = m_commits;
        wait_commits(base + 32'd8);
        check_reg("test_flush_replay", 1, snap[1] + 32'd3);
        check_reg("test_flush_replay", 3, snap[3] + 32'd2);
        check_reg("test_flush_replay", 4, snap[4] + 32'd1);
        check_regs("test_flush_replay", m_regs);
    endtask

    task automatic test_illegal();
        next_cycle();
        flush = 1'b1;
        redirect_pc = 32'd40;
        next_cycle();
        flush = 1'b0;
        base = m_illegal;
        while (illegal_count < base + 32'd1) begin
            next_cycle();
        end
        check("test_illegal illegal_count", base + 32'd1, illegal_count);
        snap = m_regs;
        base = m_commits;
        wait_commits(base + 32'd2);
        // two lone r4 increments and nothing else
        snap[4] = snap[4] + 32'd2;
        check_regs("test_illegal", snap);
    endtask

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d clock cycles", max_cycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rstn = 1'b0;
        flush = 1'b0;
        stall = 1'b0;
        redirect_pc = 32'd0;
        dbg_addr = 5'd0;
        n_checks = 0;
        n_errors = 0;
        test_reset();
        test_program();
        // forwarding starts from a clean register file
        test_reset();
        test_forwarding();
        test_stall();
        test_flush_replay();
        test_illegal();
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
source/isa_pkg.sv
source/frontend_pkg.sv
source/fetch_pc.sv
source/icache_stub.sv
source/slot_decoder.sv
source/issue_regfile.sv
source/frontend_top.sv
bench/frontend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the front end testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module frontend_tb -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vfrontend_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
    exit 0
fi
exit 1
